// ==== cacheController.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "dataCache_settings.svh"

module cacheController import dataCachePkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       clean,
  input  cpuReq_t    cpuReq,
  output cpuResp_t   cpuResp,
  output busReq_t    busReq,
  input  busResp_t   busResp,
  input  wayStatus_t wayStatus,
  output wayCtrl_t   wayCtrl
);

  cacheState_t             state;
  cacheState_t             nextState;
  logic [`OFFSET_BITS-1:0] beat;
  // Slot is {set, way} with the way in the low bit
  logic [`INDEX_BITS:0]    flushSlot;
  logic                    flushing;
  logic                    cleanDone;
  logic                    access;
  logic                    flushReq;
  logic                    lastBeat;
  logic                    victimDirty;
  logic                    flushEnd;
  logic [`TAG_BITS-1:0]    reqTag;

  assign access      = cpuReq.read | cpuReq.write;
  assign flushReq    = clean & ~cleanDone;
  assign lastBeat    = busResp.ready & (beat == `OFFSET_BITS'(`LINE_WORDS - 1));
  assign victimDirty = wayStatus.victimValid & wayStatus.victimDirty;
  assign flushEnd    = (state == FLUSH) & ~victimDirty & (flushSlot == '1);
  assign reqTag      = cpuReq.addr[31 -: `TAG_BITS];

  always_comb begin
    nextState = state;
    case (state)
      READY: begin
        if (flushReq) begin
          nextState = FLUSH;
        end else if (access && !wayStatus.hit) begin
          nextState = victimDirty ? WRITEBACK : MEMREAD;
        end
      end
      // A flush writeback returns to the walk while a miss goes on to refill
      WRITEBACK: begin
        if (lastBeat) begin
          nextState = flushing ? FLUSH : MEMREAD;
        end
      end
      MEMREAD: begin
        if (lastBeat) begin
          nextState = UPDATE;
        end
      end
      UPDATE: nextState = READY;
      FLUSH: begin
        if (victimDirty) begin
          nextState = WRITEBACK;
        end else if (flushSlot == '1) begin
          nextState = READY;
        end
      end
      default: nextState = READY;
    endcase
  end

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state <= READY;
      beat  <= '0;
    end else begin
      state <= nextState;
      // Wraps to zero after the last word of a line
      if ((state == WRITEBACK || state == MEMREAD) && busResp.ready) begin
        beat <= beat + 1'b1;
      end
    end
  end

  // Flush walk bookkeeping
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      flushSlot <= '0;
      flushing  <= 1'b0;
      cleanDone <= 1'b0;
    end else begin
      if (state == FLUSH && !victimDirty) begin
        flushSlot <= flushSlot + 1'b1;
      end
      if (state == READY && flushReq) begin
        flushing <= 1'b1;
      end else if (flushEnd) begin
        flushing <= 1'b0;
      end
      // Hold off a second walk until clean is released
      if (!clean) begin
        cleanDone <= 1'b0;
      end else if (flushEnd) begin
        cleanDone <= 1'b1;
      end
    end
  end

  always_comb begin
    wayCtrl.index = flushing ? flushSlot[`INDEX_BITS:1]
                             : cpuReq.addr[`OFFSET_BITS+2 +: `INDEX_BITS];
    wayCtrl.word  = (state == WRITEBACK || state == MEMREAD) ? beat
                                                             : cpuReq.addr[2 +: `OFFSET_BITS];
    // Target way for every operation
    if (flushing) begin
      wayCtrl.victimWay = flushSlot[0];
    end else if (state == READY && wayStatus.hit) begin
      wayCtrl.victimWay = wayStatus.hitWay;
    end else begin
      wayCtrl.victimWay = wayStatus.victimWay;
    end
    wayCtrl.refillData = busResp.readData;
    wayCtrl.op         = WAY_IDLE;
    case (state)
      READY: begin
        if (!flushReq && wayStatus.hit && cpuReq.write) begin
          wayCtrl.op = WAY_CPUWRITE;
        end else if (!flushReq && wayStatus.hit && cpuReq.read) begin
          wayCtrl.op = WAY_TOUCH;
        end
      end
      WRITEBACK: if (lastBeat) wayCtrl.op = WAY_CLEAN;
      MEMREAD:   if (busResp.ready) wayCtrl.op = WAY_REFILL;
      UPDATE:    wayCtrl.op = WAY_INSTALL;
      default:   wayCtrl.op = WAY_IDLE;
    endcase
  end

  assign cpuResp.stall    = (state != READY) | flushReq | (access & ~wayStatus.hit);
  assign cpuResp.readData = wayStatus.readData;

  assign busReq.request   = (state == WRITEBACK) | (state == MEMREAD);
  assign busReq.write     = (state == WRITEBACK);
  assign busReq.addr      = {(state == WRITEBACK) ? wayStatus.victimTag : reqTag,
                             wayCtrl.index, beat};
  assign busReq.writeData = wayStatus.victimData;

  // Line transfers are never abandoned partway
  assert property (@(posedge clk) disable iff (reset)
    (busReq.request && !lastBeat) |=> busReq.request)
    else $error("bus request dropped before the last beat");

  // Stored writes only ever come from READY outside a flush walk
  assert property (@(posedge clk) disable iff (reset)
    (wayCtrl.op == WAY_CPUWRITE) |-> (state == READY && !flushing))
    else $error("CPU write issued outside READY");

endmodule

`default_nettype wire

// ==== cacheWays.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "dataCache_settings.svh"

module cacheWays import dataCachePkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  cpuReq_t    cpuReq,
  input  wayCtrl_t   wayCtrl,
  output wayStatus_t wayStatus
);

  logic [`TAG_BITS-1:0]                tagMem  [2][`CACHE_SETS];
  logic [31:0]                         dataMem [2][`CACHE_SETS][`LINE_WORDS];
  logic [1:0][`CACHE_SETS-1:0]         validBits;
  logic [1:0][`CACHE_SETS-1:0]         dirtyBits;
  // Set bit names the least recently used way
  logic [`CACHE_SETS-1:0]              lruBits;
  logic [`TAG_BITS-1:0]                reqTag;
  logic [`INDEX_BITS-1:0]              idx;
  logic [`OFFSET_BITS-1:0]             word;
  logic                                targetWay;
  logic [1:0]                          hitVec;
  logic                                hitWay;

  assign reqTag    = cpuReq.addr[31 -: `TAG_BITS];
  assign idx       = wayCtrl.index;
  assign word      = wayCtrl.word;
  assign targetWay = wayCtrl.victimWay;

  // Tag compare
  assign hitVec[0] = validBits[0][idx] && (tagMem[0][idx] == reqTag);
  assign hitVec[1] = validBits[1][idx] && (tagMem[1][idx] == reqTag);
  assign hitWay    = hitVec[1];

  always_comb begin
    wayStatus.hit    = |hitVec;
    wayStatus.hitWay = hitWay;
    // Fill an empty way first, else evict the LRU one
    if (!validBits[0][idx]) begin
      wayStatus.victimWay = 1'b0;
    end else if (!validBits[1][idx]) begin
      wayStatus.victimWay = 1'b1;
    end else begin
      wayStatus.victimWay = lruBits[idx];
    end
    wayStatus.victimValid = validBits[targetWay][idx];
    wayStatus.victimDirty = dirtyBits[targetWay][idx];
    wayStatus.victimTag   = tagMem[targetWay][idx];
    wayStatus.victimData  = dataMem[targetWay][idx][word];
    wayStatus.readData    = dataMem[hitWay][idx][word];
  end

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      validBits <= '0;
      dirtyBits <= '0;
      lruBits   <= '0;
    end else begin
      case (wayCtrl.op)
        WAY_CPUWRITE: begin
          dirtyBits[targetWay][idx] <= 1'b1;
          lruBits[idx]              <= ~targetWay;
        end
        WAY_TOUCH: lruBits[idx] <= ~targetWay;
        WAY_INSTALL: begin
          validBits[targetWay][idx] <= 1'b1;
          dirtyBits[targetWay][idx] <= 1'b0;
          lruBits[idx]              <= ~targetWay;
        end
        WAY_CLEAN: dirtyBits[targetWay][idx] <= 1'b0;
        default: ;
      endcase
    end
  end

  // Data and tags
  always_ff @(posedge clk) begin
    if (wayCtrl.op == WAY_CPUWRITE) begin
      for (int b = 0; b < 4; b++) begin
        if (cpuReq.byteMask[b]) begin
          dataMem[targetWay][idx][word][8*b +: 8] <= cpuReq.writeData[8*b +: 8];
        end
      end
    end
    if (wayCtrl.op == WAY_REFILL) begin
      dataMem[targetWay][idx][word] <= wayCtrl.refillData;
    end
    if (wayCtrl.op == WAY_INSTALL) begin
      tagMem[targetWay][idx] <= reqTag;
    end
  end

  // A line is only installed after missing in both ways
  assert property (@(posedge clk) disable iff (reset) !(hitVec[0] && hitVec[1]))
    else $error("tag hit in both ways of set %0d", idx);

endmodule

`default_nettype wire

// ==== dataCache.f ====
+incdir+.
dataCachePkg.sv
cacheController.sv
cacheWays.sv
dataCache.sv
dataCacheTb.sv

// ==== dataCache.sv ====
`timescale 1ns/10ps
`default_nettype none

module dataCache import dataCachePkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     clean,
  input  cpuReq_t  cpuReq,
  output cpuResp_t cpuResp,
  output busReq_t  busReq,
  input  busResp_t busResp
);

  // Controller to storage and back
  wayCtrl_t   wayCtrl;
  wayStatus_t wayStatus;

  cacheController ctrl0 (
    .clk       (clk),
    .reset     (reset),
    .clean     (clean),
    .cpuReq    (cpuReq),
    .cpuResp   (cpuResp),
    .busReq    (busReq),
    .busResp   (busResp),
    .wayStatus (wayStatus),
    .wayCtrl   (wayCtrl)
  );

  // Arrays, tag compare and LRU
  cacheWays ways0 (
    .clk       (clk),
    .reset     (reset),
    .cpuReq    (cpuReq),
    .wayCtrl   (wayCtrl),
    .wayStatus (wayStatus)
  );

endmodule

`default_nettype wire

// ==== dataCachePkg.sv ====
`default_nettype none
`include "dataCache_settings.svh"

package dataCachePkg;

  // Controller sequencing states
  typedef enum logic [2:0] {
    READY,
    WRITEBACK,
    MEMREAD,
    UPDATE,
    FLUSH
  } cacheState_t;

  // Write and bookkeeping operations on the way storage
  typedef enum logic [2:0] {
    WAY_IDLE,
    WAY_CPUWRITE,
    WAY_REFILL,
    WAY_INSTALL,
    WAY_CLEAN,
    WAY_TOUCH
  } wayOp_t;

  typedef struct packed {
    logic        read;
    logic        write;
    logic [31:0] addr;
    logic [3:0]  byteMask;
    logic [31:0] writeData;
  } cpuReq_t;

  typedef struct packed {
    logic        stall;
    logic [31:0] readData;
  } cpuResp_t;

  // Word address, so two bits narrower than a byte address
  typedef struct packed {
    logic                                                request;
    logic                                                write;
    logic [`TAG_BITS+`INDEX_BITS+`OFFSET_BITS-1:0]       addr;
    logic [31:0]                                         writeData;
  } busReq_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] readData;
  } busResp_t;

  typedef struct packed {
    logic [`INDEX_BITS-1:0]  index;
    logic [`OFFSET_BITS-1:0] word;
    logic                    victimWay;
    wayOp_t                  op;
    logic [31:0]             refillData;
  } wayCtrl_t;

  typedef struct packed {
    logic                 hit;
    logic                 hitWay;
    logic                 victimWay;
    logic                 victimValid;
    logic                 victimDirty;
    logic [`TAG_BITS-1:0] victimTag;
    logic [31:0]          victimData;
    logic [31:0]          readData;
  } wayStatus_t;

endpackage

`default_nettype wire

// ==== dataCacheTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module dataCacheTb import dataCachePkg::*; ();

  localparam logic [15:0] SEED = 16'd31955;
  localparam int MEM_WORDS = 4096;
  // Whole run is well under 8000 cycles
  localparam int TIMEOUT_CYCLES = 20000;

  logic        clk = 1'b0;
  logic        reset;
  logic        clean;
  cpuReq_t     cpuReq;
  cpuResp_t    cpuResp;
  busReq_t     busReq;
  busResp_t    busResp;
  logic [31:0] memWords [MEM_WORDS];
  logic [31:0] shadow [MEM_WORDS];
  logic [15:0] memLfsr;
  logic [15:0] shadowLfsr;
  logic [15:0] stimLfsr;
  logic [31:0] memDraw;
  logic [31:0] shadowDraw;
  logic [31:0] rTag;
  logic [31:0] rSet;
  logic [31:0] rWord;
  logic [31:0] rKind;
  logic [31:0] rMask;
  logic [31:0] rData;
  logic [1:0]  waitLeft;
  logic        firstSeen;
  logic        expectHit = 1'b0;
  logic        expectMiss = 1'b0;
  logic        expectNoWrite = 1'b0;
  logic        checkActive = 1'b0;
  logic [11:0] checkIdx = '0;
  logic [11:0] reqWord;
  logic [11:0] busWord;
  int          cycleCount = 0;

  always #20 clk = ~clk;

  dataCache dut0 (
    .clk     (clk),
    .reset   (reset),
    .clean   (clean),
    .cpuReq  (cpuReq),
    .cpuResp (cpuResp),
    .busReq  (busReq),
    .busResp (busResp)
  );

  assign reqWord = cpuReq.addr[13:2];
  assign busWord = busReq.addr[11:0];

  // Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic drawBits(inout logic [15:0] s, input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], s[0]};
      s = lfsrNext(s);
    end
  endtask

  task automatic failCheck(input string msg);
    $display("[FAIL] %0t %s", $time, msg);
    $display("Regression failed");
    $fatal(1, "stopped at first failing check");
  endtask

  // Memory model answering one word per ready pulse after 0 to 3 wait cycles
  initial begin
    busResp = '0;
    memLfsr = SEED;
    for (int i = 0; i < MEM_WORDS; i++) begin
      drawBits(memLfsr, 32, memDraw);
      memWords[i] = memDraw;
    end
    drawBits(memLfsr, 2, memDraw);
    waitLeft = memDraw[1:0];
    forever begin
      @(posedge clk);
      if (reset || busResp.ready) begin
        busResp.ready <= 1'b0;
      end else if (busReq.request && waitLeft != 2'd0) begin
        waitLeft = waitLeft - 2'd1;
      end else if (busReq.request) begin
        busResp.ready    <= 1'b1;
        busResp.readData <= memWords[busWord];
        if (busReq.write) begin
          memWords[busWord] <= busReq.writeData;
        end
        drawBits(memLfsr, 2, memDraw);
        waitLeft = memDraw[1:0];
      end
    end
  end

  // Expected memory image with the model's fill plus completed CPU writes
  initial begin
    shadowLfsr = SEED;
    for (int i = 0; i < MEM_WORDS; i++) begin
      drawBits(shadowLfsr, 32, shadowDraw);
      shadow[i] = shadowDraw;
    end
    forever begin
      @(posedge clk);
      if (!reset && cpuReq.write && !cpuResp.stall) begin
        for (int b = 0; b < 4; b++) begin
          if (cpuReq.byteMask[b]) begin
            shadow[reqWord][8*b +: 8] <= cpuReq.writeData[8*b +: 8];
          end
        end
      end
    end
  end

  always @(posedge clk, posedge reset) begin
    if (reset) begin
      firstSeen <= 1'b0;
    end else if (cpuReq.read || cpuReq.write) begin
      firstSeen <= 1'b1;
    end
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Regression failed");
      $fatal(1, "simulation stopped by the cycle limit");
    end
  end

  assert property (@(posedge clk) disable iff (reset)
    (!firstSeen && !cpuReq.read && !cpuReq.write) |-> (!cpuResp.stall && !busReq.request))
    else failCheck("stall or bus request active before the first access");
  assert property (@(posedge clk) disable iff (reset)
    (cpuReq.read && !cpuResp.stall) |-> (cpuResp.readData == shadow[reqWord]))
    else failCheck("read data differs from the expected word");
  assert property (@(posedge clk) disable iff (reset)
    expectHit |-> (!cpuResp.stall && !busReq.request))
    else failCheck("expected hit stalled or used the bus");
  assert property (@(posedge clk) disable iff (reset) $rose(expectMiss) |-> cpuResp.stall)
    else failCheck("expected miss did not stall");
  assert property (@(posedge clk) disable iff (reset) $rose(expectMiss) |=> busReq.request)
    else failCheck("expected miss raised no bus request");
  assert property (@(posedge clk) disable iff (reset)
    (busReq.request && busReq.write) |-> (busReq.writeData == shadow[busWord]))
    else failCheck("writeback data differs from the expected word");
  assert property (@(posedge clk) disable iff (reset)
    (busReq.request && !busReq.write && busResp.ready) |-> (busResp.readData == shadow[busWord]))
    else failCheck("memory differs from the expected word on a refill");
  assert property (@(posedge clk) disable iff (reset)
    checkActive |-> (memWords[checkIdx] == shadow[checkIdx]))
    else failCheck("memory word not clean after flush");
  assert property (@(posedge clk) disable iff (reset)
    expectNoWrite |-> !(busReq.request && busReq.write))
    else failCheck("bus write after the flush");

  // Starts on a rising edge and returns one idle cycle after completion
  task automatic access(input logic isWrite, input logic [31:0] addr, input logic [3:0] mask,
                        input logic [31:0] data, input logic hitExp, input logic missExp);
    logic done;
    cpuReq.read      <= !isWrite;
    cpuReq.write     <= isWrite;
    cpuReq.addr      <= addr;
    cpuReq.byteMask  <= mask;
    cpuReq.writeData <= data;
    expectHit        <= hitExp;
    expectMiss       <= missExp;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      done = !cpuResp.stall;
      @(posedge clk);
    end
    cpuReq.read  <= 1'b0;
    cpuReq.write <= 1'b0;
    expectHit    <= 1'b0;
    expectMiss   <= 1'b0;
    @(posedge clk);
  endtask

  task automatic readWord(input logic [31:0] addr, input logic hitExp, input logic missExp);
    access(1'b0, addr, 4'h0, 32'h0, hitExp, missExp);
  endtask

  task automatic writeRandom(input logic [31:0] addr, input logic [3:0] mask);
    logic [31:0] data;
    drawBits(stimLfsr, 32, data);
    access(1'b1, addr, mask, data, 1'b0, 1'b0);
  endtask

  task automatic flushAll();
    logic done;
    clean <= 1'b1;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      done = !cpuResp.stall;
      @(posedge clk);
    end
    clean <= 1'b0;
    @(posedge clk);
  endtask

  task automatic checkMemory();
    checkActive <= 1'b1;
    for (int i = 0; i < MEM_WORDS; i++) begin
      checkIdx <= i[11:0];
      @(posedge clk);
    end
    checkActive <= 1'b0;
    @(posedge clk);
  endtask

  initial begin
    reset    = 1'b1;
    clean    = 1'b0;
    cpuReq   = '0;
    stimLfsr = SEED;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    repeat (3) @(posedge clk);
    // Cold miss then hit
    readWord(32'h0000_0104, 1'b0, 1'b1);
    readWord(32'h0000_0108, 1'b1, 1'b0);
    // LRU in set 5 where A and B fill ways 0 and 1 and C evicts B
    readWord(32'h0000_0250, 1'b0, 1'b1);
    readWord(32'h0000_0350, 1'b0, 1'b1);
    readWord(32'h0000_0354, 1'b1, 1'b0);
    readWord(32'h0000_0250, 1'b1, 1'b0);
    readWord(32'h0000_0450, 1'b0, 1'b1);
    readWord(32'h0000_0258, 1'b1, 1'b0);
    readWord(32'h0000_0350, 1'b0, 1'b1);
    // Partial writes in set 9 and then eviction of both dirty lines
    writeRandom(32'h0000_1090, 4'b0011);
    writeRandom(32'h0000_1094, 4'b1000);
    writeRandom(32'h0000_119C, 4'b0101);
    readWord(32'h0000_1090, 1'b1, 1'b0);
    readWord(32'h0000_1094, 1'b1, 1'b0);
    readWord(32'h0000_1290, 1'b0, 1'b1);
    readWord(32'h0000_1390, 1'b0, 1'b1);
    readWord(32'h0000_119C, 1'b0, 1'b1);
    readWord(32'h0000_1090, 1'b0, 1'b1);
    // Random mix over sets 0 to 3 with eight tags
    for (int n = 0; n < 40; n++) begin
      drawBits(stimLfsr, 3, rTag);
      drawBits(stimLfsr, 2, rSet);
      drawBits(stimLfsr, 2, rWord);
      drawBits(stimLfsr, 1, rKind);
      drawBits(stimLfsr, 4, rMask);
      drawBits(stimLfsr, 32, rData);
      if (rKind[0]) begin
        access(1'b1, {21'd0, rTag[2:0], 2'b00, rSet[1:0], rWord[1:0], 2'b00},
               (rMask[3:0] == 4'h0) ? 4'hF : rMask[3:0], rData, 1'b0, 1'b0);
      end else begin
        readWord({21'd0, rTag[2:0], 2'b00, rSet[1:0], rWord[1:0], 2'b00}, 1'b0, 1'b0);
      end
    end
    // Dirty both ways of set 12 before a flush and a full memory compare
    writeRandom(32'h0000_20C0, 4'hF);
    writeRandom(32'h0000_21C4, 4'b0110);
    flushAll();
    checkMemory();
    expectNoWrite <= 1'b1;
    readWord(32'h0000_20C0, 1'b1, 1'b0);
    readWord(32'h0000_22C0, 1'b0, 1'b1);
    readWord(32'h0000_23C4, 1'b0, 1'b1);
    readWord(32'h0000_20C0, 1'b0, 1'b1);
    expectNoWrite <= 1'b0;
    @(posedge clk);
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dataCache_settings.svh ====
`ifndef DATACACHE_SETTINGS_SVH
`define DATACACHE_SETTINGS_SVH

// Geometry of the two-way data cache
`define CACHE_SETS 16
`define LINE_WORDS 4

// Address split is tag | index | word | byte
`define INDEX_BITS 4
`define OFFSET_BITS 2
`define TAG_BITS 24

`endif

// ==== runSim.sh ====
#!/bin/sh
# Build the data cache testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module dataCacheTb -Mdir obj_dir -f dataCache.f; then
  echo "Verilator build failed"
  exit 1
fi

simOut=$(./obj_dir/VdataCacheTb)
simStatus=$?
printf '%s\n' "$simOut"
if [ "$simStatus" -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi
if printf '%s\n' "$simOut" | grep -qx "Regression passed"; then
  exit 0
fi
echo "Pass message not found in the simulation output"
exit 1
